//--- logic/pool_pkg.sv
`default_nettype none

package pool_pkg;

    localparam int WIN    = 9;  // Elements in a 3x3 window
    localparam int SORT_N = 8;  // Inputs to the bitonic network

    // IEEE half precision field split
    typedef struct packed {
        logic       sign;
        logic [4:0] exp;
        logic [9:0] man;
    } fp16_fields_t;

    // Datapath moves raw, the comparator looks at fields
    typedef union packed {
        logic [15:0]  raw;
        fp16_fields_t f;
    } fp16_u;

    // One stream beat, pixel in or pooled value out
    typedef struct packed {
        fp16_u data;
        logic  last;
    } pix_t;

    // px[0] top-left, row-major, px[8] bottom-right
    typedef struct packed {
        fp16_u [WIN-1:0] px;
    } window_t;

endpackage

`default_nettype wire

//--- logic/fp16_compare.sv
`default_nettype none
`timescale 1ns/100ps

module fp16_compare import pool_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire fp16_u a,
    input  wire fp16_u b,
    input  wire        nd,
    output logic       result,
    output logic       rdy
);

    logic a_nan;
    logic b_nan;
    logic both_zero;
    logic a_gt_b;

    assign a_nan = (a.f.exp == 5'h1f) && (a.f.man != 10'd0);
    assign b_nan = (b.f.exp == 5'h1f) && (b.f.man != 10'd0);

    // +0 and -0 are the same value
    assign both_zero = (a.f.exp == 5'd0) && (a.f.man == 10'd0)
                    && (b.f.exp == 5'd0) && (b.f.man == 10'd0);

    always_comb begin
        if (a_nan || b_nan || both_zero) begin
            a_gt_b = 1'b0;
        end else if (a.f.sign != b.f.sign) begin
            a_gt_b = !a.f.sign;
        end else if (!a.f.sign) begin
            a_gt_b = a.raw[14:0] > b.raw[14:0];  // Magnitude order
        end else begin
            a_gt_b = a.raw[14:0] < b.raw[14:0];  // Reversed for negatives
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy <= 1'b0;
        end else begin
            rdy <= nd;
        end
    end

    always_ff @(posedge clk) begin
        if (nd) begin
            result <= a_gt_b;
        end
    end

    // Every request returns a known result on the next clock
    a_rdy_after_nd: assert property (@(posedge clk) disable iff (!rst_n)
        nd |=> (rdy && !$isunknown(result)));

endmodule

`default_nettype wire

//--- logic/pool_window_gen.sv
`default_nettype none
`timescale 1ns/100ps

module pool_window_gen import pool_pkg::*; #(
    parameter int IMG_W = 12,
    parameter int IMG_H = 9
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire pix_t     pix_in,
    input  wire           pix_valid,
    output logic          pix_ready,
    output window_t       win,
    output logic          win_valid,
    input  wire           win_ready,
    output logic          win_last
);

    localparam int CW = $clog2(IMG_W);
    localparam int RW = $clog2(IMG_H);

    fp16_u         lb0 [IMG_W];  // Row 0 of the current group
    fp16_u         lb1 [IMG_W];  // Row 1 of the current group
    fp16_u [2:0]   sr;           // sr[0] newest
    logic [CW-1:0] col_q;
    logic [CW-1:0] base_q;
    logic [RW-1:0] row_q;
    logic [1:0]    csub_q;
    logic [1:0]    rsub_q;
    logic          accept;
    logic          col_end;
    logic          row_end;
    logic          win_done;

    // A held window blocks the pixel stream
    assign pix_ready = !win_valid || win_ready;
    assign accept    = pix_valid && pix_ready;
    assign col_end   = (col_q == CW'(IMG_W - 1));
    assign row_end   = (row_q == RW'(IMG_H - 1));
    assign win_done  = accept && (rsub_q == 2'd2) && (csub_q == 2'd2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_q  <= '0;
            row_q  <= '0;
            csub_q <= 2'd0;
            rsub_q <= 2'd0;
        end else if (accept) begin
            if (col_end) begin
                col_q  <= '0;
                csub_q <= 2'd0;
                row_q  <= row_end ? '0 : row_q + 1'b1;
                rsub_q <= (rsub_q == 2'd2) ? 2'd0 : rsub_q + 2'd1;
            end else begin
                col_q  <= col_q + 1'b1;
                csub_q <= (csub_q == 2'd2) ? 2'd0 : csub_q + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            case (rsub_q)
                2'd0:    lb0[col_q] <= pix_in.data;
                2'd1:    lb1[col_q] <= pix_in.data;
                default: sr <= {sr[1:0], pix_in.data};
            endcase
        end
        if (win_done) begin
            base_q   <= col_q - CW'(2);  // Left column of this window
            win_last <= col_end && row_end;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else if (win_done) begin
            win_valid <= 1'b1;
        end else if (win_ready) begin
            win_valid <= 1'b0;
        end
    end

    // Storage is frozen while the window waits
    always_comb begin
        for (int k = 0; k < 3; k++) begin
            win.px[k]     = lb0[base_q + CW'(k)];
            win.px[k + 3] = lb1[base_q + CW'(k)];
            win.px[k + 6] = sr[2 - k];
        end
    end

    // Frame length must agree with IMG_W x IMG_H
    a_last_at_frame_end: assert property (@(posedge clk) disable iff (!rst_n)
        (accept && pix_in.last) |-> (col_end && row_end));

endmodule

`default_nettype wire

//--- logic/pool_3x3.sv
`default_nettype none
`timescale 1ns/100ps

module pool_3x3 import pool_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire window_t   win,
    input  wire            win_valid,
    input  wire            win_last,
    output logic           win_ready,
    output pix_t           pool_out,
    output logic           pool_valid,
    input  wire            pool_ready
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_ISSUE = 2'd1;
    localparam logic [1:0] S_SWAP  = 2'd2;
    localparam logic [1:0] S_DONE  = 2'd3;

    localparam logic [2:0] LAST_STEP = 3'd6;  // Top of network against px[8]

    logic [1:0]              state_q;
    logic [2:0]              step_q;
    logic [SORT_N-1:0][2:0]  id_q;      // Element index held at each network position
    window_t                 win_q;
    logic                    last_q;
    logic                    last_step;
    logic [3:0][2:0]         lo_pos;
    logic [3:0][2:0]         hi_pos;    // Larger value ends up here
    fp16_u [3:0]             cmp_a;
    fp16_u [3:0]             cmp_b;
    logic [3:0]              cmp_nd;
    logic [3:0]              cmp_res;
    logic [3:0]              cmp_rdy;

    assign win_ready  = (state_q == S_IDLE);
    assign pool_valid = (state_q == S_DONE);
    assign last_step  = (step_q == LAST_STEP);

    // First three steps build asc/desc halves, last three merge ascending
    always_comb begin
        case (step_q)
            3'd0: begin
                lo_pos = {3'd7, 3'd4, 3'd3, 3'd0};
                hi_pos = {3'd6, 3'd5, 3'd2, 3'd1};
            end
            3'd1: begin
                lo_pos = {3'd7, 3'd6, 3'd1, 3'd0};
                hi_pos = {3'd5, 3'd4, 3'd3, 3'd2};
            end
            3'd2: begin
                lo_pos = {3'd7, 3'd5, 3'd2, 3'd0};
                hi_pos = {3'd6, 3'd4, 3'd3, 3'd1};
            end
            3'd3: begin
                lo_pos = {3'd3, 3'd2, 3'd1, 3'd0};
                hi_pos = {3'd7, 3'd6, 3'd5, 3'd4};
            end
            3'd4: begin
                lo_pos = {3'd5, 3'd4, 3'd1, 3'd0};
                hi_pos = {3'd7, 3'd6, 3'd3, 3'd2};
            end
            3'd5: begin
                lo_pos = {3'd6, 3'd4, 3'd2, 3'd0};
                hi_pos = {3'd7, 3'd5, 3'd3, 3'd1};
            end
            default: begin
                lo_pos = {4{3'd7}};
                hi_pos = {4{3'd7}};
            end
        endcase
    end

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            cmp_a[c] = win_q.px[id_q[lo_pos[c]]];
            cmp_b[c] = last_step ? win_q.px[WIN-1] : win_q.px[id_q[hi_pos[c]]];
        end
    end

    assign cmp_nd = (state_q != S_ISSUE) ? 4'b0000 :
                    last_step            ? 4'b0001 : 4'b1111;

    fp16_compare cmp_0 (.clk(clk), .rst_n(rst_n), .a(cmp_a[0]), .b(cmp_b[0]),
                        .nd(cmp_nd[0]), .result(cmp_res[0]), .rdy(cmp_rdy[0]));
    fp16_compare cmp_1 (.clk(clk), .rst_n(rst_n), .a(cmp_a[1]), .b(cmp_b[1]),
                        .nd(cmp_nd[1]), .result(cmp_res[1]), .rdy(cmp_rdy[1]));
    fp16_compare cmp_2 (.clk(clk), .rst_n(rst_n), .a(cmp_a[2]), .b(cmp_b[2]),
                        .nd(cmp_nd[2]), .result(cmp_res[2]), .rdy(cmp_rdy[2]));
    fp16_compare cmp_3 (.clk(clk), .rst_n(rst_n), .a(cmp_a[3]), .b(cmp_b[3]),
                        .nd(cmp_nd[3]), .result(cmp_res[3]), .rdy(cmp_rdy[3]));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            step_q  <= 3'd0;
            for (int i = 0; i < SORT_N; i++) begin
                id_q[i] <= 3'(i);
            end
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (win_valid) begin
                        state_q <= S_ISSUE;
                        step_q  <= 3'd0;
                        for (int i = 0; i < SORT_N; i++) begin
                            id_q[i] <= 3'(i);  // Fresh order per window
                        end
                    end
                end
                S_ISSUE: state_q <= S_SWAP;
                S_SWAP: begin
                    if (cmp_rdy[0]) begin
                        for (int c = 0; c < 4; c++) begin
                            if (!last_step && cmp_rdy[c] && cmp_res[c]) begin
                                id_q[lo_pos[c]] <= id_q[hi_pos[c]];
                                id_q[hi_pos[c]] <= id_q[lo_pos[c]];
                            end
                        end
                        if (last_step) begin
                            state_q <= S_DONE;
                        end else begin
                            step_q  <= step_q + 3'd1;
                            state_q <= S_ISSUE;
                        end
                    end
                end
                default: begin
                    if (pool_ready) begin
                        state_q <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid && win_ready) begin
            win_q  <= win;
            last_q <= win_last;
        end
        if (state_q == S_SWAP && last_step && cmp_rdy[0]) begin
            pool_out.data <= cmp_res[0] ? cmp_a[0] : cmp_b[0];  // Ties go to px[8]
            pool_out.last <= last_q;
        end
    end

    // Seven two-clock steps, result shows 15 clocks after its window is taken
    a_result_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(pool_valid) |-> $past(win_valid && win_ready, 15));

endmodule

`default_nettype wire

//--- logic/pool_engine.sv
`default_nettype none
`timescale 1ns/100ps

module pool_engine import pool_pkg::*; #(
    parameter int IMG_W = 12,
    parameter int IMG_H = 9
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire pix_t  pix_in,
    input  wire        pix_valid,
    output logic       pix_ready,
    output pix_t       pool_out,
    output logic       pool_valid,
    input  wire        pool_ready
);

    window_t win;
    logic    win_valid;
    logic    win_ready;
    logic    win_last;  // Rides along with the final window of a frame

    pool_window_gen #(
        .IMG_W(IMG_W),
        .IMG_H(IMG_H)
    ) pool_window_gen_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_in    (pix_in),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .win       (win),
        .win_valid (win_valid),
        .win_ready (win_ready),
        .win_last  (win_last)
    );

    pool_3x3 pool_3x3_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .win        (win),
        .win_valid  (win_valid),
        .win_last   (win_last),
        .win_ready  (win_ready),
        .pool_out   (pool_out),
        .pool_valid (pool_valid),
        .pool_ready (pool_ready)
    );

endmodule

`default_nettype wire

//--- test/pool_ref.svh
`ifndef POOL_REF_SVH
`define POOL_REF_SVH

// Signed ordering key, both zeros land on 0
function automatic int fp16_key(input logic [15:0] v);
    int mag;
    mag = int'(v[14:0]);
    return v[15] ? -mag : mag;
endfunction

function automatic bit fp16_is_nan(input logic [15:0] v);
    return (v[14:10] == 5'h1f) && (v[9:0] != 10'd0);
endfunction

// A NaN never wins
function automatic bit fp16_gt_ref(input logic [15:0] a, input logic [15:0] b);
    if (fp16_is_nan(a) || fp16_is_nan(b)) begin
        return 1'b0;
    end
    return fp16_key(a) > fp16_key(b);
endfunction

// Pools stored frame f and queues its results in raster order
function automatic void pool_frame_ref(input int f);
    logic [15:0] best;
    logic [15:0] v;
    pix_t        e;
    int          n;
    n = 0;
    for (int wr = 0; wr < IMG_H; wr += 3) begin
        for (int wc = 0; wc < IMG_W; wc += 3) begin
            best = frames[f][wr * IMG_W + wc];
            for (int k = 1; k < 9; k++) begin
                v = frames[f][(wr + k / 3) * IMG_W + wc + k % 3];
                if (fp16_gt_ref(v, best)) begin
                    best = v;
                end
            end
            n++;
            e.data.raw = best;
            e.last     = (n == (IMG_W / 3) * (IMG_H / 3));  // Final window of the frame
            exp_q.push_back(e);
        end
    end
endfunction

`endif

//--- test/pool_engine_tb.sv
`default_nettype none
`timescale 1ns/100ps

module pool_engine_tb import pool_pkg::*; ();

    localparam int IMG_W    = 12;
    localparam int IMG_H    = 9;
    localparam int FRAME_PX = IMG_W * IMG_H;
    localparam int FRAMES   = 4;
    localparam int OUTS     = FRAMES * (IMG_W / 3) * (IMG_H / 3);
    localparam int TIMEOUT  = FRAMES * FRAME_PX * 20 + 500;

    logic        clk;
    logic        rst_n;
    pix_t        pix_in;
    logic        pix_valid;
    logic        pix_ready;
    pix_t        pool_out;
    logic        pool_valid;
    logic        pool_ready;
    logic [15:0] frames [FRAMES][FRAME_PX];
    pix_t        exp_q [$];
    int          out_cnt;
    int          cycle_cnt;
    bit          gaps_on;  // Random stalls on both streams

    `include "pool_ref.svh"

    pool_engine #(
        .IMG_W(IMG_W),
        .IMG_H(IMG_H)
    ) pool_engine_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_in     (pix_in),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .pool_out   (pool_out),
        .pool_valid (pool_valid),
        .pool_ready (pool_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected 0x%04h got 0x%04h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Never a zero, never Inf or NaN
    function automatic logic [15:0] rand_fp16(input bit neg);
        logic [4:0] e;
        logic [9:0] m;
        e = 5'($urandom_range(0, 30));
        m = 10'($urandom);
        if (e == 5'd0 && m == 10'd0) begin
            m = 10'd1;
        end
        return {neg, e, m};
    endfunction

    task automatic make_frames();
        int w;
        for (int i = 0; i < FRAME_PX; i++) begin
            w = (i / IMG_W / 3) * (IMG_W / 3) + (i % IMG_W) / 3;
            frames[0][i] = rand_fp16(1'b0);
            frames[1][i] = rand_fp16(w < 4 ? 1'b1 : 1'($urandom_range(0, 1)));
            frames[2][i] = rand_fp16(1'b0);
            frames[3][i] = rand_fp16(1'($urandom_range(0, 1)));
        end
        frames[1][1 * IMG_W + 1] = 16'hfc00;  // -Inf among negatives
        frames[1][2 * IMG_W + 4] = 16'h7c00;  // +Inf
        frames[1][0 * IMG_W + 7] = 16'h8000;  // -0 tops window 2
        frames[1][1 * IMG_W + 9] = 16'h0000;  // +0 tops window 3
        // Window 4 has both zeros under a tiny positive
        frames[1][4 * IMG_W + 0] = 16'h0000;
        frames[1][5 * IMG_W + 2] = 16'h8000;
        frames[1][3 * IMG_W + 1] = 16'h0001;
    endtask

    task automatic send_frame(input int f);
        for (int i = 0; i < FRAME_PX; i++) begin
            if (gaps_on && $urandom_range(0, 3) == 0) begin
                pix_valid <= 1'b0;
                repeat ($urandom_range(1, 3)) @(posedge clk);
            end
            pix_in.data.raw <= frames[f][i];
            pix_in.last     <= (i == FRAME_PX - 1);
            pix_valid       <= 1'b1;
            @(posedge clk);
            while (!pix_ready) begin
                @(posedge clk);
            end
        end
        pix_valid <= 1'b0;
    endtask

    always @(posedge clk) begin
        if (gaps_on) begin
            pool_ready <= ($urandom_range(0, 2) != 0);
        end else begin
            pool_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin : compare_out
        pix_t e;
        if (rst_n && pool_valid && pool_ready) begin
            if (exp_q.size() == 0) begin
                $display("More pooled outputs arrived than the frames can produce");
                $display("Test failed");
                $fatal(1, "Extra output");
            end else begin
                e = exp_q.pop_front();
                check_value("pool_out.data", e.data.raw, pool_out.data.raw);
                check_value("pool_out.last", 16'(e.last), 16'(pool_out.last));
                out_cnt <= out_cnt + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout, only %0d of %0d pooled outputs arrived", out_cnt, OUTS);
            $display("Test failed");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        void'($urandom(62));
        rst_n      = 1'b0;
        pix_in     = '0;
        pix_valid  = 1'b0;
        pool_ready = 1'b1;
        gaps_on    = 1'b0;
        out_cnt    = 0;
        cycle_cnt  = 0;
        make_frames();
        for (int f = 0; f < FRAMES; f++) begin
            pool_frame_ref(f);
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("pool_valid", 16'd0, 16'(pool_valid));
        check_value("pix_ready", 16'd1, 16'(pix_ready));
        send_frame(0);  // Positive values, no stalls
        send_frame(1);  // Mixed signs and specials
        gaps_on <= 1'b1;
        send_frame(2);
        send_frame(3);
        while (out_cnt < OUTS) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);  // Room for a stray extra output
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+test
logic/pool_pkg.sv
logic/fp16_compare.sv
logic/pool_window_gen.sv
logic/pool_3x3.sv
logic/pool_engine.sv
test/pool_engine_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the pooling engine testbench with Verilator and runs it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module pool_engine_tb \
    --Mdir "$BUILD_DIR" \
    -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vpool_engine_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "Simulation passed"
exit 0
